/* mips_decode_pkg.sv */
package mips_decode_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [7:0]  op_t;
    typedef logic [4:0]  reg_idx_t;  // also used for shamt
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [31:0] imm_t;

    localparam reg_idx_t REG_RA = 5'd31;  // link register

    // major opcodes
    localparam opcode_t OPC_SPECIAL  = 6'h00;
    localparam opcode_t OPC_J        = 6'h02;
    localparam opcode_t OPC_JAL      = 6'h03;
    localparam opcode_t OPC_BEQ      = 6'h04;
    localparam opcode_t OPC_BNE      = 6'h05;
    localparam opcode_t OPC_BLEZ     = 6'h06;
    localparam opcode_t OPC_BGTZ     = 6'h07;
    localparam opcode_t OPC_ADDI     = 6'h08;
    localparam opcode_t OPC_ADDIU    = 6'h09;
    localparam opcode_t OPC_SLTI     = 6'h0a;
    localparam opcode_t OPC_SLTIU    = 6'h0b;
    localparam opcode_t OPC_ANDI     = 6'h0c;
    localparam opcode_t OPC_ORI      = 6'h0d;
    localparam opcode_t OPC_XORI     = 6'h0e;
    localparam opcode_t OPC_LUI      = 6'h0f;
    localparam opcode_t OPC_COP0     = 6'h10;
    localparam opcode_t OPC_SPECIAL2 = 6'h1c;
    localparam opcode_t OPC_LW       = 6'h23;
    localparam opcode_t OPC_SW       = 6'h2b;

    localparam op_t OP_INVALID = 8'h00;

    // R group
    localparam op_t OP_SLL     = 8'h01;
    localparam op_t OP_SRL     = 8'h02;
    localparam op_t OP_SRA     = 8'h03;
    localparam op_t OP_SLLV    = 8'h04;
    localparam op_t OP_SRLV    = 8'h05;
    localparam op_t OP_SRAV    = 8'h06;
    localparam op_t OP_JR      = 8'h07;
    localparam op_t OP_JALR    = 8'h08;
    localparam op_t OP_MOVZ    = 8'h09;
    localparam op_t OP_MOVN    = 8'h0a;
    localparam op_t OP_SYSCALL = 8'h0b;
    localparam op_t OP_MFHI    = 8'h0c;
    localparam op_t OP_MTHI    = 8'h0d;
    localparam op_t OP_MFLO    = 8'h0e;
    localparam op_t OP_MTLO    = 8'h0f;
    localparam op_t OP_MULT    = 8'h10;
    localparam op_t OP_DIV     = 8'h11;
    localparam op_t OP_ADD     = 8'h12;
    localparam op_t OP_SUB     = 8'h13;
    localparam op_t OP_AND     = 8'h14;
    localparam op_t OP_OR      = 8'h15;
    localparam op_t OP_XOR     = 8'h16;
    localparam op_t OP_NOR     = 8'h17;
    localparam op_t OP_SLT     = 8'h18;
    localparam op_t OP_MFC0    = 8'h19;
    localparam op_t OP_MADD    = 8'h1a;
    localparam op_t OP_MUL     = 8'h1b;
    localparam op_t OP_MSUB    = 8'h1c;
    localparam op_t OP_CLZ     = 8'h1d;
    localparam op_t OP_CLO     = 8'h1e;

    // I/J group
    localparam op_t OP_LUI     = 8'h20;
    localparam op_t OP_LW      = 8'h21;
    localparam op_t OP_SW      = 8'h22;
    localparam op_t OP_BEQ     = 8'h23;
    localparam op_t OP_BNE     = 8'h24;
    localparam op_t OP_BLEZ    = 8'h25;
    localparam op_t OP_BGTZ    = 8'h26;
    localparam op_t OP_J       = 8'h27;
    localparam op_t OP_JAL     = 8'h28;

endpackage

/* id_r.sv */
`timescale 1ns/1ps

module id_r
    import mips_decode_pkg::*;
(
    input  inst_t    inst,
    output op_t      op,
    output reg_idx_t reg_w,
    output logic     flag_unsigned
);

    opcode_t opcode;
    funct_t  funct;
    op_t     op_special;
    op_t     op_special2;
    logic    uns_special;
    logic    uns_special2;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];

    always_comb begin
        case (funct)
            6'h00:         op_special = OP_SLL;
            6'h02:         op_special = OP_SRL;
            6'h03:         op_special = OP_SRA;
            6'h04:         op_special = OP_SLLV;
            6'h06:         op_special = OP_SRLV;
            6'h07:         op_special = OP_SRAV;
            6'h08:         op_special = OP_JR;
            6'h09:         op_special = OP_JALR;
            6'h0a:         op_special = OP_MOVZ;
            6'h0b:         op_special = OP_MOVN;
            6'h0c:         op_special = OP_SYSCALL;
            6'h10:         op_special = OP_MFHI;
            6'h11:         op_special = OP_MTHI;
            6'h12:         op_special = OP_MFLO;
            6'h13:         op_special = OP_MTLO;
            6'h18, 6'h19:  op_special = OP_MULT;  // mult, multu
            6'h1a, 6'h1b:  op_special = OP_DIV;
            6'h20, 6'h21:  op_special = OP_ADD;
            6'h22, 6'h23:  op_special = OP_SUB;
            6'h24:         op_special = OP_AND;
            6'h25:         op_special = OP_OR;
            6'h26:         op_special = OP_XOR;
            6'h27:         op_special = OP_NOR;
            6'h2a, 6'h2b:  op_special = OP_SLT;
            default:       op_special = OP_INVALID;
        endcase
    end

    always_comb begin
        case (funct)
            6'h00, 6'h01:  op_special2 = OP_MADD;  // madd, maddu
            6'h02:         op_special2 = OP_MUL;
            6'h04, 6'h05:  op_special2 = OP_MSUB;
            6'h20:         op_special2 = OP_CLZ;
            6'h21:         op_special2 = OP_CLO;
            default:       op_special2 = OP_INVALID;
        endcase
    end

    // only functs that also decode to a valid op
    assign uns_special  = funct inside {6'h19, 6'h1b, 6'h21, 6'h23, 6'h2b};
    assign uns_special2 = funct inside {6'h01, 6'h05};

    always_comb begin
        op            = OP_INVALID;
        flag_unsigned = 1'b0;
        case (opcode)
            OPC_SPECIAL: begin
                op            = op_special;
                flag_unsigned = uns_special;
            end
            OPC_SPECIAL2: begin
                op            = op_special2;
                flag_unsigned = uns_special2;
            end
            OPC_COP0: begin
                if (inst[25:21] == 5'h00) op = OP_MFC0;  // mf sub-op only
            end
            default: ;
        endcase
    end

    assign reg_w = (op == OP_MFC0) ? inst[20:16] : inst[15:11];  // mfc0 writes rt

endmodule

/* id_ij.sv */
`timescale 1ns/1ps

module id_ij
    import mips_decode_pkg::*;
(
    input  inst_t    inst,
    output op_t      op,
    output reg_idx_t reg_w,
    output imm_t     imm,
    output logic     flag_unsigned
);

    opcode_t  opcode;
    reg_idx_t rt;
    imm_t     imm_sign;
    imm_t     imm_zero;
    imm_t     imm_lui;
    imm_t     imm_target;

    assign opcode     = inst[31:26];
    assign rt         = inst[20:16];
    assign imm_sign   = {{16{inst[15]}}, inst[15:0]};
    assign imm_zero   = {16'h0000, inst[15:0]};
    assign imm_lui    = {inst[15:0], 16'h0000};
    assign imm_target = {6'b000000, inst[25:0]};  // 26-bit jump target

    always_comb begin
        op            = OP_INVALID;
        reg_w         = '0;  // zero means no write
        imm           = '0;
        flag_unsigned = 1'b0;
        case (opcode)
            OPC_ADDI, OPC_ADDIU: begin
                op            = OP_ADD;
                reg_w         = rt;
                imm           = imm_sign;
                flag_unsigned = (opcode == OPC_ADDIU);
            end
            OPC_SLTI, OPC_SLTIU: begin
                op            = OP_SLT;
                reg_w         = rt;
                imm           = imm_sign;
                flag_unsigned = (opcode == OPC_SLTIU);
            end
            OPC_ANDI: begin
                op    = OP_AND;
                reg_w = rt;
                imm   = imm_zero;
            end
            OPC_ORI: begin
                op    = OP_OR;
                reg_w = rt;
                imm   = imm_zero;
            end
            OPC_XORI: begin
                op    = OP_XOR;
                reg_w = rt;
                imm   = imm_zero;
            end
            OPC_LUI: begin
                op    = OP_LUI;
                reg_w = rt;
                imm   = imm_lui;
            end
            OPC_LW: begin
                op    = OP_LW;
                reg_w = rt;
                imm   = imm_sign;
            end
            OPC_SW: begin
                op  = OP_SW;
                imm = imm_sign;
            end
            OPC_BEQ: begin
                op  = OP_BEQ;
                imm = imm_sign;
            end
            OPC_BNE: begin
                op  = OP_BNE;
                imm = imm_sign;
            end
            OPC_BLEZ: begin
                op  = OP_BLEZ;
                imm = imm_sign;
            end
            OPC_BGTZ: begin
                op  = OP_BGTZ;
                imm = imm_sign;
            end
            OPC_J: begin
                op  = OP_J;
                imm = imm_target;
            end
            OPC_JAL: begin
                op    = OP_JAL;
                reg_w = REG_RA;  // link
                imm   = imm_target;
            end
            default: ;
        endcase
    end

endmodule

/* id_stage.sv */
`timescale 1ns/1ps

module id_stage
    import mips_decode_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     inst_valid,
    input  inst_t    inst,
    input  logic     stall,
    input  logic     flush,
    output logic     out_valid,
    output op_t      op,
    output reg_idx_t reg_s,
    output reg_idx_t reg_t,
    output reg_idx_t reg_w,
    output reg_idx_t shift,
    output imm_t     imm,
    output logic     flag_unsigned
);

    op_t      r_op;
    reg_idx_t r_reg_w;
    logic     r_unsigned;

    op_t      ij_op;
    reg_idx_t ij_reg_w;
    imm_t     ij_imm;
    logic     ij_unsigned;

    logic     sel_r;
    logic     load;
    op_t      dec_op;
    reg_idx_t dec_reg_w;
    imm_t     dec_imm;
    logic     dec_unsigned;

    id_r i_id_r (
        .inst          (inst),
        .op            (r_op),
        .reg_w         (r_reg_w),
        .flag_unsigned (r_unsigned)
    );

    id_ij i_id_ij (
        .inst          (inst),
        .op            (ij_op),
        .reg_w         (ij_reg_w),
        .imm           (ij_imm),
        .flag_unsigned (ij_unsigned)
    );

    // the two decoders never both claim an opcode
    assign sel_r        = (r_op != OP_INVALID);
    assign dec_op       = sel_r ? r_op       : ij_op;
    assign dec_reg_w    = sel_r ? r_reg_w    : ij_reg_w;
    assign dec_imm      = sel_r ? '0         : ij_imm;
    assign dec_unsigned = sel_r ? r_unsigned : ij_unsigned;

    assign load = inst_valid && !stall && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;  // wins over stall
        end else if (!stall) begin
            out_valid <= inst_valid;
        end
    end

    // data holds on idle, stall and flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op            <= OP_INVALID;
            reg_s         <= '0;
            reg_t         <= '0;
            reg_w         <= '0;
            shift         <= '0;
            imm           <= '0;
            flag_unsigned <= 1'b0;
        end else if (load) begin
            op            <= dec_op;
            reg_s         <= inst[25:21];
            reg_t         <= inst[20:16];
            reg_w         <= dec_reg_w;
            shift         <= inst[10:6];
            imm           <= dec_imm;
            flag_unsigned <= dec_unsigned;
        end
    end

endmodule

/* id_stage_checker.sv */
`timescale 1ns/1ps

module id_stage_checker
    import mips_decode_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     stall,
    input logic     flush,
    input logic     out_valid,
    input op_t      op,
    input reg_idx_t reg_s,
    input reg_idx_t reg_t,
    input reg_idx_t reg_w,
    input reg_idx_t shift,
    input imm_t     imm,
    input logic     flag_unsigned
);

    int fails = 0;

    flush_clears_valid: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !out_valid)
        else begin
            fails++;
            $error("out_valid still high on the cycle after flush");
        end

    stall_holds_outputs: assert property (@(posedge clk) disable iff (!rst_n)
        stall && !flush |=> $stable(out_valid) && $stable(op) && $stable(imm)
            && $stable({reg_s, reg_t, reg_w, shift}) && $stable(flag_unsigned))
        else begin
            fails++;
            $error("outputs changed across a stall cycle");
        end

    op_known: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !$isunknown(op))
        else begin
            fails++;
            $error("op has unknown bits while out_valid is high");
        end

endmodule

bind id_stage id_stage_checker i_checker (.*);

/* tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage
    import mips_decode_pkg::*;
();

    logic     clk;
    logic     rst_n;
    logic     inst_valid;
    inst_t    inst;
    logic     stall;
    logic     flush;
    logic     out_valid;
    op_t      op;
    reg_idx_t reg_s;
    reg_idx_t reg_t;
    reg_idx_t reg_w;
    reg_idx_t shift;
    imm_t     imm;
    logic     flag_unsigned;

    string t_name[$];
    inst_t t_tmpl[$];
    inst_t t_mask[$];
    op_t   t_op[$];
    logic  t_uns[$];
    string t_imm_kind[$];
    string t_dst_kind[$];

    logic [31:0] lfsr = 32'he988_8e93;
    inst_t       m_r = 32'h03ff_ffc0;    // rs, rt, rd, shamt
    inst_t       m_c0 = 32'h001f_ffff;   // rs stays fixed
    inst_t       m_ij = 32'h03ff_ffff;
    inst_t       m_neg = 32'h03ff_7fff;  // imm sign bit from template
    inst_t       neg = 32'h0000_8000;
    int          wait_limit = 10;
    int          checks = 0;
    int          value_errors = 0;
    int          timeouts = 0;

    id_stage i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .stall         (stall),
        .flush         (flush),
        .out_valid     (out_valid),
        .op            (op),
        .reg_s         (reg_s),
        .reg_t         (reg_t),
        .reg_w         (reg_w),
        .shift         (shift),
        .imm           (imm),
        .flag_unsigned (flag_unsigned)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    function automatic inst_t r_word(input opcode_t opc, input funct_t fn);
        return {opc, 20'h00000, fn};
    endfunction

    function automatic inst_t i_word(input opcode_t opc);
        return {opc, 26'h0000000};
    endfunction

    function automatic imm_t expect_imm(input string kind, input inst_t w);
        case (kind)
            "sign":   return {{16{w[15]}}, w[15:0]};
            "zero":   return {16'h0000, w[15:0]};
            "lui":    return {w[15:0], 16'h0000};
            "target": return {6'b000000, w[25:0]};
            default:  return '0;
        endcase
    endfunction

    function automatic reg_idx_t expect_dst(input string kind, input inst_t w);
        case (kind)
            "rd":    return w[15:11];
            "rt":    return w[20:16];
            "ra":    return 5'd31;
            default: return 5'd0;  // no write
        endcase
    endfunction

    task automatic add_entry(input string name, input inst_t tmpl, input inst_t mask,
                             input op_t exp_op, input logic uns, input string ikind,
                             input string dkind);
        t_name.push_back(name);
        t_tmpl.push_back(tmpl);
        t_mask.push_back(mask);
        t_op.push_back(exp_op);
        t_uns.push_back(uns);
        t_imm_kind.push_back(ikind);
        t_dst_kind.push_back(dkind);
    endtask

    // one lfsr step per random bit
    task automatic fill_fields(input inst_t tmpl, input inst_t mask, output inst_t word);
        word = tmpl;
        for (int b = 0; b < 32; b++) begin
            if (mask[b]) begin
                lfsr    = lfsr_next(lfsr);
                word[b] = lfsr[0];
            end
        end
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("ERROR %s %s: expected %h, actual %h", name, field, exp, act);
        end
    endtask

    task automatic check_decode(input int i, input inst_t w);
        check_value(t_name[i], "op", t_op[i], op);
        check_value(t_name[i], "flag_unsigned", t_uns[i], flag_unsigned);
        check_value(t_name[i], "reg_s", w[25:21], reg_s);
        check_value(t_name[i], "reg_t", w[20:16], reg_t);
        check_value(t_name[i], "reg_w", expect_dst(t_dst_kind[i], w), reg_w);
        check_value(t_name[i], "shift", w[10:6], shift);
        check_value(t_name[i], "imm", expect_imm(t_imm_kind[i], w), imm);
    endtask

    task automatic wait_valid(input string name, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (out_valid !== 1'b1 && cycles < wait_limit);
        if (out_valid !== 1'b1) begin
            timeouts++;
            $display("timeout: out_valid never went high for %s", name);
        end
    endtask

    task automatic apply_entry(input int i);
        inst_t w;
        int    lat;
        fill_fields(t_tmpl[i], t_mask[i], w);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= w;
        @(posedge clk);
        inst_valid <= 1'b0;
        wait_valid(t_name[i], lat);
        check_value(t_name[i], "latency", 1, lat);
        check_decode(i, w);
    endtask

    task automatic flush_case(input string name, input int i, input int j,
                              input logic with_stall);
        inst_t w;
        inst_t other;
        fill_fields(t_tmpl[i], t_mask[i], w);
        fill_fields(t_tmpl[j], t_mask[j], other);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= w;
        @(posedge clk);
        inst       <= other;  // offered, never taken
        stall      <= with_stall;
        flush      <= 1'b1;
        @(negedge clk);
        check_value(name, "out_valid before flush", 1, out_valid);
        @(posedge clk);
        inst_valid <= 1'b0;
        stall      <= 1'b0;
        flush      <= 1'b0;
        @(negedge clk);
        check_value(name, "out_valid", 0, out_valid);
        check_decode(i, w);  // data left as it was
    endtask

    task automatic build_table();
        add_entry("addu", r_word(OPC_SPECIAL, 6'h21), m_r, OP_ADD, 1, "none", "rd");
        add_entry("lui", i_word(OPC_LUI), m_ij, OP_LUI, 0, "lui", "rt");
        add_entry("jal", i_word(OPC_JAL), m_ij, OP_JAL, 0, "target", "ra");
        add_entry("add", r_word(OPC_SPECIAL, 6'h20), m_r, OP_ADD, 0, "none", "rd");
        add_entry("sll", r_word(OPC_SPECIAL, 6'h00), m_r, OP_SLL, 0, "none", "rd");
        add_entry("sra", r_word(OPC_SPECIAL, 6'h03), m_r, OP_SRA, 0, "none", "rd");
        add_entry("jr", r_word(OPC_SPECIAL, 6'h08), m_r, OP_JR, 0, "none", "rd");
        add_entry("mfhi", r_word(OPC_SPECIAL, 6'h10), m_r, OP_MFHI, 0, "none", "rd");
        add_entry("multu", r_word(OPC_SPECIAL, 6'h19), m_r, OP_MULT, 1, "none", "rd");
        add_entry("divu", r_word(OPC_SPECIAL, 6'h1b), m_r, OP_DIV, 1, "none", "rd");
        add_entry("subu", r_word(OPC_SPECIAL, 6'h23), m_r, OP_SUB, 1, "none", "rd");
        add_entry("sltu", r_word(OPC_SPECIAL, 6'h2b), m_r, OP_SLT, 1, "none", "rd");
        add_entry("maddu", r_word(OPC_SPECIAL2, 6'h01), m_r, OP_MADD, 1, "none", "rd");
        add_entry("msubu", r_word(OPC_SPECIAL2, 6'h05), m_r, OP_MSUB, 1, "none", "rd");
        add_entry("clz", r_word(OPC_SPECIAL2, 6'h20), m_r, OP_CLZ, 0, "none", "rd");
        add_entry("mfc0", i_word(OPC_COP0), m_c0, OP_MFC0, 0, "none", "rt");
        add_entry("addi_neg", i_word(OPC_ADDI) | neg, m_neg, OP_ADD, 0, "sign", "rt");
        add_entry("addiu", i_word(OPC_ADDIU), m_ij, OP_ADD, 1, "sign", "rt");
        add_entry("slti_neg", i_word(OPC_SLTI) | neg, m_neg, OP_SLT, 0, "sign", "rt");
        add_entry("sltiu", i_word(OPC_SLTIU), m_ij, OP_SLT, 1, "sign", "rt");
        add_entry("andi_neg", i_word(OPC_ANDI) | neg, m_neg, OP_AND, 0, "zero", "rt");
        add_entry("ori", i_word(OPC_ORI), m_ij, OP_OR, 0, "zero", "rt");
        add_entry("xori", i_word(OPC_XORI), m_ij, OP_XOR, 0, "zero", "rt");
        add_entry("lw_neg", i_word(OPC_LW) | neg, m_neg, OP_LW, 0, "sign", "rt");
        add_entry("sw", i_word(OPC_SW), m_ij, OP_SW, 0, "sign", "none");
        add_entry("beq_neg", i_word(OPC_BEQ) | neg, m_neg, OP_BEQ, 0, "sign", "none");
        add_entry("bgtz", i_word(OPC_BGTZ), m_ij, OP_BGTZ, 0, "sign", "none");
        add_entry("j", i_word(OPC_J), m_ij, OP_J, 0, "target", "none");
        add_entry("bad_opcode", i_word(6'h3f), m_ij, OP_INVALID, 0, "none", "none");
        add_entry("bad_special", r_word(OPC_SPECIAL, 6'h01), m_r, OP_INVALID, 0, "none", "none");
        add_entry("bad_special2", r_word(OPC_SPECIAL2, 6'h03), m_r, OP_INVALID, 0, "none",
                  "none");
        // rs = 4 is mtc0, not decoded here
        add_entry("bad_cop0", i_word(OPC_COP0) | 32'h0080_0000, m_c0, OP_INVALID, 0, "none",
                  "none");
    endtask

    initial begin
        inst_t words[3];
        inst_t held;
        inst_t offered;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        stall      = 1'b0;
        flush      = 1'b0;
        build_table();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset", "out_valid", 0, out_valid);
        check_value("reset", "op", OP_INVALID, op);
        check_value("reset", "imm", 0, imm);
        check_value("reset", "reg_s", 0, reg_s);
        check_value("reset", "reg_t", 0, reg_t);
        check_value("reset", "reg_w", 0, reg_w);
        check_value("reset", "shift", 0, shift);
        check_value("reset", "flag_unsigned", 0, flag_unsigned);

        for (int i = 0; i < t_name.size(); i++) begin
            apply_entry(i);
        end

        // back to back, one result per cycle
        for (int i = 0; i < 3; i++) begin
            fill_fields(t_tmpl[i], t_mask[i], words[i]);
        end
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            inst_valid <= (i < 3);
            inst       <= words[i % 3];
            if (i > 0) begin
                @(negedge clk);
                check_value("back_to_back", "out_valid", 1, out_valid);
                check_decode(i - 1, words[i - 1]);
            end
        end
        @(posedge clk);
        inst_valid <= 1'b0;

        // stall with a new word waiting upstream
        fill_fields(t_tmpl[0], t_mask[0], held);
        fill_fields(t_tmpl[1], t_mask[1], offered);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= held;
        @(posedge clk);
        stall <= 1'b1;
        inst  <= offered;
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            check_value("stall", "out_valid", 1, out_valid);
            check_decode(0, held);
        end
        @(posedge clk);
        stall <= 1'b0;
        @(posedge clk);
        inst_valid <= 1'b0;
        @(negedge clk);
        check_value("stall_release", "out_valid", 1, out_valid);
        check_decode(1, offered);

        flush_case("flush", 2, 1, 1'b0);
        flush_case("flush_during_stall", 0, 1, 1'b1);

        repeat (2) @(posedge clk);
        $display("checks: %0d, value errors: %0d, timeouts: %0d, assertion failures: %0d",
                 checks, value_errors, timeouts, i_dut.i_checker.fails);
        if (value_errors == 0 && timeouts == 0 && i_dut.i_checker.fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* mips_decode.f */
mips_decode_pkg.sv
id_r.sv
id_ij.sv
id_stage.sv
id_stage_checker.sv
tb_id_stage.sv

/* Bender.yml */
package:
  name: mips_decode

sources:
  - mips_decode_pkg.sv
  - id_r.sv
  - id_ij.sv
  - id_stage.sv
  - target: simulation
    files:
      - id_stage_checker.sv
      - tb_id_stage.sv
